/* fetch_frontend.f */
+incdir+include
src/cpu_types_pkg.sv
src/predictor_pkg.sv
src/predictor_unit.sv
src/branch_target_buffer.sv
src/branch_predictor.sv
src/fetch_address_unit.sv
src/fetch_frontend.sv
bench/fetch_frontend_tb.sv

/* run.sh */
#!/bin/sh
# Build the fetch front end testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f fetch_frontend.f \
    --top-module fetch_frontend_tb -o fetch_frontend_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/fetch_frontend_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi

if ! grep -q "TEST PASSED" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi

exit 0

/* bench/fetch_frontend_tb.sv */
`default_nettype none
`timescale 1ns/1ps

`include "fetch_consts.svh"

module fetch_frontend_tb;

    import cpu_types_pkg::*;

    localparam int IDX_BITS = $clog2(`BTB_SIZE);

    logic       clk_i;
    logic       reset_i;
    logic       flush_i;
    logic       stall_i;
    logic       exec_valid_i;
    data_word_t exec_pc_i;
    data_word_t exec_target_i;
    logic       exec_taken_i;
    logic       exec_branch_i;
    logic       exec_jump_i;
    logic       exec_pred_taken_i;
    data_word_t exec_pred_target_i;
    data_word_t fetch_pc_o;
    data_word_t predicted_target_o;
    logic       prediction_o;
    logic       hit_o;
    logic       mispredicted_o;

    // The model keeps one copy of every table plus the program counter
    logic       m_valid  [`BTB_SIZE];
    data_word_t m_tag    [`BTB_SIZE];
    data_word_t m_target [`BTB_SIZE];
    logic       m_jump   [`BTB_SIZE];
    logic [1:0] m_ctr    [`PREDICTOR_SIZE];
    data_word_t m_pc;

    string cur_test;
    int    checks;
    int    errors;
    int    test_start_errors;

    fetch_frontend fetch_frontend_i (
        .clk_i              ( clk_i              ),
        .reset_i            ( reset_i            ),
        .flush_i            ( flush_i            ),
        .stall_i            ( stall_i            ),
        .exec_valid_i       ( exec_valid_i       ),
        .exec_pc_i          ( exec_pc_i          ),
        .exec_target_i      ( exec_target_i      ),
        .exec_taken_i       ( exec_taken_i       ),
        .exec_branch_i      ( exec_branch_i      ),
        .exec_jump_i        ( exec_jump_i        ),
        .exec_pred_taken_i  ( exec_pred_taken_i  ),
        .exec_pred_target_i ( exec_pred_target_i ),
        .fetch_pc_o         ( fetch_pc_o         ),
        .predicted_target_o ( predicted_target_o ),
        .prediction_o       ( prediction_o       ),
        .hit_o              ( hit_o              ),
        .mispredicted_o     ( mispredicted_o     )
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    // ----------------------------------------
    // Reference model
    // ----------------------------------------

    // Packs {target, prediction, hit, mispredicted} for the current model state
    function automatic logic [34:0] predict_outputs(input data_word_t pc);
        int         bi;
        int         ci;
        logic       hit;
        logic       pred;
        logic       mis;
        bi   = (pc >> 2) % `BTB_SIZE;
        ci   = (pc >> 2) % `PREDICTOR_SIZE;
        hit  = m_valid[bi] && (m_tag[bi] == (pc >> (2 + IDX_BITS)));
        pred = hit && (m_jump[bi] || m_ctr[ci] >= 2'd2);
        mis  = exec_valid_i && (exec_branch_i || exec_jump_i) &&
               ((exec_pred_taken_i != exec_taken_i) ||
                (exec_taken_i && exec_pred_target_i != exec_target_i));
        return {m_target[bi], pred, hit, mis};
    endfunction

    task automatic advance_model(input logic [34:0] exp);
        int ei;
        int ci;
        ei = (exec_pc_i >> 2) % `BTB_SIZE;
        ci = (exec_pc_i >> 2) % `PREDICTOR_SIZE;
        if (reset_i) begin
            m_pc = `RESET_VECTOR;
        end else if (exp[0]) begin
            m_pc = exec_taken_i ? exec_target_i : exec_pc_i + `INSTR_BYTES;
        end else if (!stall_i) begin
            m_pc = exp[2] ? exp[34:3] : m_pc + `INSTR_BYTES;
        end
        if (exec_valid_i && (exec_branch_i || exec_jump_i) && exec_taken_i) begin
            m_tag[ei]    = exec_pc_i >> (2 + IDX_BITS);
            m_target[ei] = exec_target_i;
            m_jump[ei]   = exec_jump_i;
        end
        if (reset_i) begin
            for (int i = 0; i < `PREDICTOR_SIZE; i++) begin
                m_ctr[i] = 2'd1;
            end
        end else if (exec_valid_i && exec_branch_i) begin
            // Counters saturate at 0 for strongly not taken and at 3 for strongly taken
            if (exec_taken_i && m_ctr[ci] != 2'd3) begin
                m_ctr[ci] = m_ctr[ci] + 2'd1;
            end
            if (!exec_taken_i && m_ctr[ci] != 2'd0) begin
                m_ctr[ci] = m_ctr[ci] - 2'd1;
            end
        end
        if (reset_i || flush_i) begin
            for (int i = 0; i < `BTB_SIZE; i++) begin
                m_valid[i] = 1'b0;
            end
        end else if (exec_valid_i && (exec_branch_i || exec_jump_i) && exec_taken_i) begin
            m_valid[ei] = 1'b1;
        end
    endtask

    task automatic check_value(input string what, input data_word_t exp, input data_word_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("[ERROR] %s %s expected %h actual %h", cur_test, what, exp, act);
        end
    endtask

    // Outputs are stable at the falling edge, inputs changed half a cycle ago
    initial begin : compare_process
        logic [34:0] exp;
        forever begin
            @(negedge clk_i);
            exp = predict_outputs(m_pc);
            check_value("fetch_pc_o", m_pc, fetch_pc_o);
            check_value("hit_o", 32'(exp[1]), 32'(hit_o));
            check_value("prediction_o", 32'(exp[2]), 32'(prediction_o));
            check_value("mispredicted_o", 32'(exp[0]), 32'(mispredicted_o));
            if (exp[1]) begin
                check_value("predicted_target_o", exp[34:3], predicted_target_o);
            end
            advance_model(exp);
        end
    end

    // ----------------------------------------
    // Stimulus helpers
    // ----------------------------------------

    task automatic drive_report(input data_word_t pc, input data_word_t target,
                                input logic taken, input logic branch, input logic jump,
                                input logic pred_taken, input data_word_t pred_target);
        @(posedge clk_i);
        exec_valid_i       <= 1'b1;
        exec_pc_i          <= pc;
        exec_target_i      <= target;
        exec_taken_i       <= taken;
        exec_branch_i      <= branch;
        exec_jump_i        <= jump;
        exec_pred_taken_i  <= pred_taken;
        exec_pred_target_i <= pred_target;
    endtask

    task automatic idle_cycle();
        @(posedge clk_i);
        exec_valid_i <= 1'b0;
        flush_i      <= 1'b0;
    endtask

    // Waits until fetch reaches an address, gives up after a number of cycles
    task automatic wait_for_fetch(input data_word_t addr, input int limit);
        int   n;
        logic ok;
        ok = 1'b0;
        n  = 0;
        while (!ok && n < limit) begin
            @(negedge clk_i);
            ok = (fetch_pc_o == addr);
            n++;
        end
        if (!ok) begin
            errors++;
            $display("%s: fetch never reached address %h", cur_test, addr);
        end
    endtask

    task automatic finish_test();
        $display("test %s finished with %0d errors", cur_test, errors - test_start_errors);
        test_start_errors = errors;
    endtask

    task automatic start_test(input string name);
        cur_test = name;
    endtask

    // Hard limit on the whole run
    initial begin : watchdog
        #2_000_000;
        $display("Simulation timed out");
        $display("TEST FAILED");
        $finish;
    end

    initial begin : stimulus
        void'($urandom(32'hd36c_d46e));
        reset_i = 1'b1;
        flush_i = 1'b0;
        stall_i = 1'b0;
        exec_valid_i = 1'b0;
        exec_pc_i = '0;
        exec_target_i = '0;
        exec_taken_i = 1'b0;
        exec_branch_i = 1'b0;
        exec_jump_i = 1'b0;
        exec_pred_taken_i = 1'b0;
        exec_pred_target_i = '0;
        checks = 0;
        errors = 0;
        test_start_errors = 0;
        m_pc = `RESET_VECTOR;
        for (int i = 0; i < `BTB_SIZE; i++) begin
            m_valid[i] = 1'b0;
            m_tag[i] = '0;
            m_target[i] = '0;
            m_jump[i] = 1'b0;
        end
        for (int i = 0; i < `PREDICTOR_SIZE; i++) begin
            m_ctr[i] = 2'd1;
        end

        start_test("reset");
        repeat (3) @(posedge clk_i);
        reset_i <= 1'b0;
        @(negedge clk_i);
        check_value("fetch_pc_o after reset", `RESET_VECTOR, fetch_pc_o);
        check_value("hit_o after reset", 32'd0, 32'(hit_o));
        check_value("prediction_o after reset", 32'd0, 32'(prediction_o));
        finish_test();

        start_test("sequential_stall");
        repeat (3) idle_cycle();
        @(posedge clk_i);
        stall_i <= 1'b1;
        repeat (3) idle_cycle();
        @(posedge clk_i);
        stall_i <= 1'b0;
        repeat (2) idle_cycle();
        finish_test();

        // A taken branch at 0x1040 makes its counter weakly taken
        start_test("training");
        drive_report(32'h1040, 32'h1200, 1'b1, 1'b1, 1'b0, 1'b1, 32'h1200);
        idle_cycle();
        wait_for_fetch(32'h1040, 40);
        check_value("prediction_o at trained branch", 32'd1, 32'(prediction_o));
        wait_for_fetch(32'h1200, 2);
        drive_report(32'h1208, 32'h1300, 1'b1, 1'b0, 1'b1, 1'b1, 32'h1300);
        idle_cycle();
        wait_for_fetch(32'h1208, 10);
        check_value("prediction_o at jump", 32'd1, 32'(prediction_o));
        wait_for_fetch(32'h1300, 2);
        finish_test();

        start_test("counter_decay");
        repeat (3) drive_report(32'h1040, 32'h1200, 1'b0, 1'b1, 1'b0, 1'b0, 32'h0);
        // A wrongly predicted branch just before sends fetch back to 0x1040
        drive_report(32'h103c, 32'h1800, 1'b0, 1'b1, 1'b0, 1'b1, 32'h1800);
        idle_cycle();
        wait_for_fetch(32'h1040, 4);
        check_value("hit_o after decay", 32'd1, 32'(hit_o));
        check_value("prediction_o after decay", 32'd0, 32'(prediction_o));
        finish_test();

        start_test("mispredict_stall");
        @(posedge clk_i);
        stall_i <= 1'b1;
        drive_report(32'h1500, 32'h1600, 1'b1, 1'b0, 1'b1, 1'b0, 32'h0);
        @(negedge clk_i);
        check_value("mispredicted_o", 32'd1, 32'(mispredicted_o));
        idle_cycle();
        wait_for_fetch(32'h1600, 3);
        @(posedge clk_i);
        stall_i <= 1'b0;
        finish_test();

        start_test("flush_random");
        @(posedge clk_i);
        flush_i <= 1'b1;
        idle_cycle();
        drive_report(32'h103c, 32'h1800, 1'b0, 1'b1, 1'b0, 1'b1, 32'h1800);
        idle_cycle();
        wait_for_fetch(32'h1040, 4);
        check_value("hit_o after flush", 32'd0, 32'(hit_o));
        for (int n = 0; n < 300; n++) begin
            @(posedge clk_i);
            // Addresses stay in a small window so the tables alias often
            stall_i            <= ($urandom % 4) == 0;
            flush_i            <= ($urandom % 50) == 0;
            exec_valid_i       <= ($urandom % 3) == 0;
            exec_pc_i          <= 32'h1000 + (($urandom % 64) << 2);
            exec_target_i      <= 32'h1000 + (($urandom % 128) << 2);
            exec_taken_i       <= ($urandom % 2) == 0;
            exec_branch_i      <= ($urandom % 3) != 0;
            exec_jump_i        <= 1'b0;
            exec_pred_taken_i  <= ($urandom % 2) == 0;
            exec_pred_target_i <= 32'h1000 + (($urandom % 128) << 2);
            if (($urandom % 5) == 0) begin
                exec_branch_i <= 1'b0;
                exec_jump_i   <= 1'b1;
            end
        end
        @(posedge clk_i);
        stall_i <= 1'b0;
        idle_cycle();
        @(negedge clk_i);
        finish_test();

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule : fetch_frontend_tb

`default_nettype wire

/* src/fetch_frontend.sv */
`default_nettype none
`timescale 1ns/1ps

module fetch_frontend (
    input  logic                      clk_i,
    input  logic                      reset_i,
    input  logic                      flush_i,
    input  logic                      stall_i,

    // Execute reports one strobe per resolved instruction
    input  logic                      exec_valid_i,
    input  cpu_types_pkg::data_word_t exec_pc_i,
    input  cpu_types_pkg::data_word_t exec_target_i,
    input  logic                      exec_taken_i,
    input  logic                      exec_branch_i,
    input  logic                      exec_jump_i,
    input  logic                      exec_pred_taken_i,
    input  cpu_types_pkg::data_word_t exec_pred_target_i,

    // Fetch address and its prediction
    output cpu_types_pkg::data_word_t fetch_pc_o,
    output cpu_types_pkg::data_word_t predicted_target_o,
    output logic                      prediction_o,
    output logic                      hit_o,
    output logic                      mispredicted_o
);

    // ----------------------------------------
    // Program counter
    // ----------------------------------------

    // The predictor outputs loop straight back into next-address selection
    fetch_address_unit fetch_address_unit_i (
        .clk_i              ( clk_i              ),
        .reset_i            ( reset_i            ),
        .stall_i            ( stall_i            ),
        .prediction_i       ( prediction_o       ),
        .predicted_target_i ( predicted_target_o ),
        .mispredicted_i     ( mispredicted_o     ),
        .exec_taken_i       ( exec_taken_i       ),
        .exec_target_i      ( exec_target_i      ),
        .exec_pc_i          ( exec_pc_i          ),
        .fetch_pc_o         ( fetch_pc_o         )
    );

    // ----------------------------------------
    // Predictor
    // ----------------------------------------

    branch_predictor branch_predictor_i (
        .clk_i              ( clk_i              ),
        .reset_i            ( reset_i            ),
        .flush_i            ( flush_i            ),
        .fetch_pc_i         ( fetch_pc_o         ),
        .exec_valid_i       ( exec_valid_i       ),
        .exec_pc_i          ( exec_pc_i          ),
        .exec_target_i      ( exec_target_i      ),
        .exec_taken_i       ( exec_taken_i       ),
        .exec_branch_i      ( exec_branch_i      ),
        .exec_jump_i        ( exec_jump_i        ),
        .exec_pred_taken_i  ( exec_pred_taken_i  ),
        .exec_pred_target_i ( exec_pred_target_i ),
        .predicted_target_o ( predicted_target_o ),
        .prediction_o       ( prediction_o       ),
        .mispredicted_o     ( mispredicted_o     ),
        .hit_o              ( hit_o              )
    );

endmodule : fetch_frontend

`default_nettype wire

/* src/fetch_address_unit.sv */
`default_nettype none
`timescale 1ns/1ps

`include "fetch_consts.svh"

module fetch_address_unit (
    input  logic                      clk_i,
    input  logic                      reset_i,
    input  logic                      stall_i,

    // Prediction for the address fetched this cycle
    input  logic                      prediction_i,
    input  cpu_types_pkg::data_word_t predicted_target_i,

    // Correction from execute
    input  logic                      mispredicted_i,
    input  logic                      exec_taken_i,
    input  cpu_types_pkg::data_word_t exec_target_i,
    input  cpu_types_pkg::data_word_t exec_pc_i,

    output cpu_types_pkg::data_word_t fetch_pc_o
);

    import cpu_types_pkg::*;

    data_word_t redirect_pc;
    data_word_t next_pc;

    // ----------------------------------------
    // Next address selection
    // ----------------------------------------

    // Correct path after a misprediction
    // A not-taken branch resumes at the instruction right after it
    assign redirect_pc = exec_taken_i ? exec_target_i : exec_pc_i + `INSTR_BYTES;

    // A redirect must not be lost, so it beats the stall
    always_comb begin
        if (mispredicted_i) begin
            next_pc = redirect_pc;
        end else if (stall_i) begin
            next_pc = fetch_pc_o;
        end else if (prediction_i) begin
            next_pc = predicted_target_i;
        end else begin
            next_pc = fetch_pc_o + `INSTR_BYTES;
        end
    end

    // ----------------------------------------
    // Program counter register
    // ----------------------------------------

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            fetch_pc_o <= `RESET_VECTOR;
        end else begin
            fetch_pc_o <= next_pc;
        end
    end

    // Targets from the BTB and from execute must keep fetch on word boundaries
    pc_aligned_a: assert property (
        @(posedge clk_i) disable iff (reset_i)
        fetch_pc_o[$clog2(`INSTR_BYTES)-1:0] == '0
    );

endmodule : fetch_address_unit

`default_nettype wire

/* src/branch_predictor.sv */
`default_nettype none
`timescale 1ns/1ps

`include "fetch_consts.svh"

module branch_predictor #(
    // Number of pattern table counters
    parameter int PREDICTOR_SIZE = `PREDICTOR_SIZE,
    // Number of BTB entries
    parameter int BTB_SIZE       = `BTB_SIZE
) (
    input  logic                      clk_i,
    input  logic                      reset_i,
    input  logic                      flush_i,

    // Address being fetched this cycle
    input  cpu_types_pkg::data_word_t fetch_pc_i,

    // Execute report
    input  logic                      exec_valid_i,
    input  cpu_types_pkg::data_word_t exec_pc_i,
    input  cpu_types_pkg::data_word_t exec_target_i,
    input  logic                      exec_taken_i,
    input  logic                      exec_branch_i,
    input  logic                      exec_jump_i,
    input  logic                      exec_pred_taken_i,
    input  cpu_types_pkg::data_word_t exec_pred_target_i,

    // Prediction for the current fetch address
    output cpu_types_pkg::data_word_t predicted_target_o,
    output logic                      prediction_o,
    output logic                      mispredicted_o,
    output logic                      hit_o
);

    // The jump flag of the matching entry steers the counter bypass
    logic btb_is_jump;

    // ----------------------------------------
    // Branch target buffer
    // ----------------------------------------

    branch_target_buffer #(
        .BTB_SIZE      ( BTB_SIZE           )
    ) branch_target_buffer_i (
        .clk_i         ( clk_i              ),
        .reset_i       ( reset_i            ),
        .flush_i       ( flush_i            ),
        .lookup_pc_i   ( fetch_pc_i         ),
        .exec_valid_i  ( exec_valid_i       ),
        .exec_pc_i     ( exec_pc_i          ),
        .exec_target_i ( exec_target_i      ),
        .exec_taken_i  ( exec_taken_i       ),
        .exec_branch_i ( exec_branch_i      ),
        .exec_jump_i   ( exec_jump_i        ),
        .target_o      ( predicted_target_o ),
        .is_jump_o     ( btb_is_jump        ),
        .hit_o         ( hit_o              )
    );

    // ----------------------------------------
    // Counter table and final decision
    // ----------------------------------------

    predictor_unit #(
        .PREDICTOR_SIZE     ( PREDICTOR_SIZE     )
    ) predictor_unit_i (
        .clk_i              ( clk_i              ),
        .reset_i            ( reset_i            ),
        .lookup_pc_i        ( fetch_pc_i         ),
        .hit_i              ( hit_o              ),
        .is_jump_i          ( btb_is_jump        ),
        .exec_valid_i       ( exec_valid_i       ),
        .exec_pc_i          ( exec_pc_i          ),
        .exec_branch_i      ( exec_branch_i      ),
        .exec_jump_i        ( exec_jump_i        ),
        .exec_taken_i       ( exec_taken_i       ),
        .exec_target_i      ( exec_target_i      ),
        .exec_pred_taken_i  ( exec_pred_taken_i  ),
        .exec_pred_target_i ( exec_pred_target_i ),
        .prediction_o       ( prediction_o       ),
        .mispredicted_o     ( mispredicted_o     )
    );

    // Execute never reports an instruction as both a branch and a jump
    // Both tables would otherwise disagree on how to treat the entry
    branch_or_jump_a: assert property (
        @(posedge clk_i) disable iff (reset_i)
        !(exec_branch_i && exec_jump_i)
    );

endmodule : branch_predictor

`default_nettype wire

/* src/branch_target_buffer.sv */
`default_nettype none
`timescale 1ns/1ps

`include "fetch_consts.svh"

module branch_target_buffer #(
    parameter int BTB_SIZE = `BTB_SIZE
) (
    input  logic                      clk_i,
    input  logic                      reset_i,
    input  logic                      flush_i,

    // Current fetch address
    input  cpu_types_pkg::data_word_t lookup_pc_i,

    // Resolved instruction from execute
    input  logic                      exec_valid_i,
    input  cpu_types_pkg::data_word_t exec_pc_i,
    input  cpu_types_pkg::data_word_t exec_target_i,
    input  logic                      exec_taken_i,
    input  logic                      exec_branch_i,
    input  logic                      exec_jump_i,

    // Lookup result
    output cpu_types_pkg::data_word_t target_o,
    output logic                      is_jump_o,
    output logic                      hit_o
);

    import cpu_types_pkg::*;
    import predictor_pkg::*;

    // ----------------------------------------
    // Entry storage
    // ----------------------------------------

    // Valid bits are control state, the rest is payload
    logic [BTB_SIZE-1:0] valid_q;
    btb_tag_t            tag_q    [BTB_SIZE];
    data_word_t          target_q [BTB_SIZE];
    logic                jump_q   [BTB_SIZE];

    btb_index_t lookup_idx;
    btb_tag_t   lookup_tag;
    btb_index_t exec_idx;
    btb_tag_t   exec_tag;
    logic       write_en;

    // Index sits right above the byte offset, the tag takes everything above it
    assign lookup_idx = lookup_pc_i[OFFSET_BITS +: $bits(btb_index_t)];
    assign lookup_tag = lookup_pc_i[OFFSET_BITS + $bits(btb_index_t) +: $bits(btb_tag_t)];
    assign exec_idx   = exec_pc_i[OFFSET_BITS +: $bits(btb_index_t)];
    assign exec_tag   = exec_pc_i[OFFSET_BITS + $bits(btb_index_t) +: $bits(btb_tag_t)];

    // ----------------------------------------
    // Lookup
    // ----------------------------------------

    // An invalid entry never hits, whatever its stale tag holds
    assign hit_o     = valid_q[lookup_idx] && (tag_q[lookup_idx] == lookup_tag);
    assign target_o  = target_q[lookup_idx];
    assign is_jump_o = jump_q[lookup_idx];

    // ----------------------------------------
    // Update
    // ----------------------------------------

    // Only taken control transfers are worth caching
    // A not-taken branch simply falls through, which fetch does anyway
    assign write_en = exec_valid_i && (exec_branch_i || exec_jump_i) && exec_taken_i;

    // Flush wins over a write in the same cycle, so the table comes out empty
    always_ff @(posedge clk_i) begin
        if (reset_i || flush_i) begin
            valid_q <= '0;
        end else if (write_en) begin
            valid_q[exec_idx] <= 1'b1;
        end
    end

    // Payload is overwritten in place, the old entry at this index is lost
    always_ff @(posedge clk_i) begin
        if (write_en) begin
            tag_q[exec_idx]    <= exec_tag;
            target_q[exec_idx] <= exec_target_i;
            jump_q[exec_idx]   <= exec_jump_i;
        end
    end

    // After a flush nothing may hit until execute writes a new entry
    no_hit_after_flush_a: assert property (
        @(posedge clk_i) disable iff (reset_i)
        flush_i |=> !hit_o
    );

endmodule : branch_target_buffer

`default_nettype wire

/* src/predictor_unit.sv */
`default_nettype none
`timescale 1ns/1ps

`include "fetch_consts.svh"

module predictor_unit #(
    parameter int PREDICTOR_SIZE = `PREDICTOR_SIZE
) (
    input  logic                     clk_i,
    input  logic                     reset_i,

    // The BTB drives the lookup side in the same cycle
    input  cpu_types_pkg::data_word_t lookup_pc_i,
    input  logic                     hit_i,
    input  logic                     is_jump_i,

    // Resolved instruction from execute
    input  logic                     exec_valid_i,
    input  cpu_types_pkg::data_word_t exec_pc_i,
    input  logic                     exec_branch_i,
    input  logic                     exec_jump_i,
    input  logic                     exec_taken_i,
    input  cpu_types_pkg::data_word_t exec_target_i,
    input  logic                     exec_pred_taken_i,
    input  cpu_types_pkg::data_word_t exec_pred_target_i,

    output logic                     prediction_o,
    output logic                     mispredicted_o
);

    import predictor_pkg::*;

    // ----------------------------------------
    // Counter table
    // ----------------------------------------

    counter_state_t pht [PREDICTOR_SIZE];

    pht_index_t     lookup_idx;
    pht_index_t     exec_idx;
    counter_state_t lookup_state;
    logic           counter_taken;
    logic           exec_resolved;
    logic           target_wrong;

    // One step of the 2-bit counter, saturating at both ends
    function automatic counter_state_t step_counter(input counter_state_t state,
                                                    input logic taken);
        counter_state_t next_state;
        case (state)
            STRONG_NT: next_state = taken ? WEAK_NT  : STRONG_NT;
            WEAK_NT:   next_state = taken ? WEAK_T   : STRONG_NT;
            WEAK_T:    next_state = taken ? STRONG_T : WEAK_NT;
            STRONG_T:  next_state = taken ? STRONG_T : WEAK_T;
            default:   next_state = WEAK_NT;
        endcase
        return next_state;
    endfunction

    // Both ports index the table with the word address bits right above the byte offset
    assign lookup_idx = lookup_pc_i[OFFSET_BITS +: $bits(pht_index_t)];
    assign exec_idx   = exec_pc_i[OFFSET_BITS +: $bits(pht_index_t)];

    // ----------------------------------------
    // Final prediction
    // ----------------------------------------

    assign lookup_state  = pht[lookup_idx];
    assign counter_taken = (lookup_state == WEAK_T) || (lookup_state == STRONG_T);

    // Jumps are always taken once known, branches follow their counter
    assign prediction_o = hit_i && (is_jump_i || counter_taken);

    // ----------------------------------------
    // Misprediction detection
    // ----------------------------------------

    assign exec_resolved = exec_valid_i && (exec_branch_i || exec_jump_i);

    // A right taken guess can still send fetch to the wrong place
    assign target_wrong = exec_pred_taken_i && exec_taken_i &&
                          (exec_pred_target_i != exec_target_i);

    assign mispredicted_o = exec_resolved &&
                            ((exec_pred_taken_i != exec_taken_i) || target_wrong);

    // Counters start weakly not taken so a single taken report flips them
    // Only conditional branches train the table
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < PREDICTOR_SIZE; i++) begin
                pht[i] <= WEAK_NT;
            end
        end else if (exec_valid_i && exec_branch_i) begin
            pht[exec_idx] <= step_counter(pht[exec_idx], exec_taken_i);
        end
    end

    // Fetch is only redirected while execute presents a resolved instruction
    mispredict_needs_exec_a: assert property (
        @(posedge clk_i) disable iff (reset_i)
        mispredicted_o |-> exec_valid_i
    );

endmodule : predictor_unit

`default_nettype wire

/* src/predictor_pkg.sv */
`default_nettype none

`include "fetch_consts.svh"

// ----------------------------------------
// Branch predictor types
// ----------------------------------------

package predictor_pkg;

    // Low address bits that only select a byte inside the instruction word
    localparam int OFFSET_BITS = $clog2(`INSTR_BYTES);

    // Address slice widths for the two tables
    localparam int BTB_INDEX_BITS = $clog2(`BTB_SIZE);
    localparam int PHT_INDEX_BITS = $clog2(`PREDICTOR_SIZE);

    // Tag holds every address bit above the BTB index
    localparam int BTB_TAG_BITS = $bits(cpu_types_pkg::data_word_t) - OFFSET_BITS - BTB_INDEX_BITS;

    // The upper bit of the counter state alone tells taken from not taken
    typedef enum logic [1:0] {
        STRONG_NT = 2'b00,
        WEAK_NT   = 2'b01,
        WEAK_T    = 2'b10,
        STRONG_T  = 2'b11
    } counter_state_t;

    typedef logic [BTB_INDEX_BITS-1:0] btb_index_t;
    typedef logic [BTB_TAG_BITS-1:0]   btb_tag_t;
    typedef logic [PHT_INDEX_BITS-1:0] pht_index_t;

endpackage : predictor_pkg

`default_nettype wire

/* src/cpu_types_pkg.sv */
`default_nettype none

// ----------------------------------------
// Core-wide types
// ----------------------------------------

package cpu_types_pkg;

    // Width of a machine word on this core
    localparam int WORD_BITS = 32;

    // One machine word
    // Used for fetch addresses, branch targets and resolved PCs alike
    typedef logic [WORD_BITS-1:0] data_word_t;

endpackage : cpu_types_pkg

`default_nettype wire

/* include/fetch_consts.svh */
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// ----------------------------------------
// Predictor table sizes
// ----------------------------------------

// Number of 2-bit saturating counters in the pattern table
`define PREDICTOR_SIZE 32

// Number of entries in the direct-mapped branch target buffer
`define BTB_SIZE 32

// ----------------------------------------
// Fetch address constants
// ----------------------------------------

// First address fetched after reset
`define RESET_VECTOR 32'h0000_1000

// Every instruction is one 32-bit word, so the fetch address steps by this much
`define INSTR_BYTES 4

`endif
